// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_core_glue
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/av_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types for the pixel enable and audio capture path
// Samples are signed. A mono core must drive both channels itself
////////////////////////////////////////////////////////////////////////////

`include "core_defs.svh"

package av_pkg;

    // One audio channel as delivered by the game
    typedef logic signed [`CORE_SND_W-1:0] snd_sample_t;

endpackage

// ==== hdl/av_strobe_align.sv ====
////////////////////////////////////////////////////////////////////////////
// Pixel-centre enable and stereo sample capture
// pxl1_cen lags its inputs by one cycle
// Audio samples are held until the next game sample strobe
// Both strobes are single-cycle and come from the clk_sys domain
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_defs.svh"

module av_strobe_align (
    input  logic                clk_sys,
    input  logic                sys_rst,
    input  logic                pxl2_cen,
    input  logic                pxl_cen,
    input  av_pkg::snd_sample_t snd_left,
    input  av_pkg::snd_sample_t snd_right,
    input  logic                snd_sample,
    output logic                pxl1_cen,
    output av_pkg::snd_sample_t audio_l,
    output av_pkg::snd_sample_t audio_r
);
    import av_pkg::*;

    snd_sample_t left_q;
    snd_sample_t right_q;

    // Double-rate enable without the single-rate one lands mid pixel
    always_ff @(posedge clk_sys or posedge sys_rst) begin
        if (sys_rst) begin
            pxl1_cen <= 1'b0;
        end else begin
            pxl1_cen <= pxl2_cen & ~pxl_cen;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Audio capture

    always_ff @(posedge clk_sys or posedge sys_rst) begin
        if (sys_rst) begin
            left_q  <= '0;
            right_q <= '0;
        end else if (snd_sample) begin
            left_q  <= snd_left;
            right_q <= snd_right;
        end
    end

    assign audio_l = left_q;
    assign audio_r = right_q;

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Back-to-back centre strobes need back-to-back double-rate enables
    a_cen_spacing : assert property (
        @(posedge clk_sys) disable iff (sys_rst)
        pxl1_cen && $past(pxl1_cen) |-> $past(pxl2_cen) && $past(pxl2_cen, 2)
    ) else $error("pxl1_cen repeated without a matching pxl2_cen");

endmodule

// ==== hdl/clk_rst_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Types for the PLL supervisor and the game reset logic
// Widths follow the constants in core_defs.svh
////////////////////////////////////////////////////////////////////////////

`include "core_defs.svh"

package clk_rst_pkg;

    // Hold counter, sized for CORE_PLL_RST_CYCLES minus one
    typedef logic [$clog2(`CORE_PLL_RST_CYCLES)-1:0] rst_count_t;

    // Status vector coming from the OSD
    typedef logic [`CORE_STATUS_W-1:0] status_word_t;

    // One bit per release stage, MSB drives the game reset
    typedef logic [`CORE_RST_SYNC_STAGES-1:0] rst_sync_t;

    // PLL supervisor FSM
    typedef enum logic {
        PLL_RUN  = 1'b0,
        PLL_HOLD = 1'b1
    } pll_state_t;

endpackage

// ==== hdl/core_defs.svh ====
////////////////////////////////////////////////////////////////////////////
// Board glue constants, shared by the packages and all RTL modules
// All values are global to the design. No module overrides them
// CORE_PLL_RST_CYCLES must fit in clk_rst_pkg::rst_count_t
////////////////////////////////////////////////////////////////////////////

`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// PLL reset hold after a lock loss, in clk_sys cycles
`define CORE_PLL_RST_CYCLES 256

// Depth of the game reset release chain
`define CORE_RST_SYNC_STAGES 2

// Signed audio sample width per channel
`define CORE_SND_W 16

// OSD status word
`define CORE_STATUS_W 64
`define CORE_STATUS_RST_BIT 0

`endif

// ==== hdl/core_glue_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Board glue top: PLL supervisor, game reset and A/V strobe logic
// Single clock domain. Every input is assumed synchronous to clk_sys,
// sys_rst excepted, which is asynchronous and active high
// The vendor PLL sits outside and takes pll_rst back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_defs.svh"

module core_glue_top (
    input  logic                      clk_sys,
    input  logic                      sys_rst,
    // PLL and reset sources
    input  logic                      pll_locked,
    input  clk_rst_pkg::status_word_t status,
    input  logic                      osd_button,
    // Game video enables
    input  logic                      pxl2_cen,
    input  logic                      pxl_cen,
    // Game audio
    input  av_pkg::snd_sample_t       snd_left,
    input  av_pkg::snd_sample_t       snd_right,
    input  logic                      snd_sample,
    // To the PLL and the game
    output logic                      pll_rst,
    output logic                      game_rst,
    output logic                      pxl1_cen,
    output av_pkg::snd_sample_t       audio_l,
    output av_pkg::snd_sample_t       audio_r
);

    ////////////////////////////////////////////////////////////////////////////
    // Clocking and reset

    pll_lock_monitor u_pll_mon (
        .clk_sys    ( clk_sys    ),
        .sys_rst    ( sys_rst    ),
        .pll_locked ( pll_locked ),
        .pll_rst    ( pll_rst    )
    );

    // Sees the raw lock level, so the game stays in reset while unlocked
    game_reset_ctrl u_game_rst (
        .clk_sys    ( clk_sys    ),
        .sys_rst    ( sys_rst    ),
        .status     ( status     ),
        .osd_button ( osd_button ),
        .pll_locked ( pll_locked ),
        .game_rst   ( game_rst   )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Video and audio

    av_strobe_align u_av (
        .clk_sys    ( clk_sys    ),
        .sys_rst    ( sys_rst    ),
        .pxl2_cen   ( pxl2_cen   ),
        .pxl_cen    ( pxl_cen    ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample ),
        .pxl1_cen   ( pxl1_cen   ),
        .audio_l    ( audio_l    ),
        .audio_r    ( audio_r    )
    );

endmodule

// ==== hdl/game_reset_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// Game reset from the system reset, OSD status, user button and PLL lock
// sys_rst sets the reset asynchronously, the other sources on the clock
// Release takes CORE_RST_SYNC_STAGES edges with every request low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_defs.svh"

module game_reset_ctrl (
    input  logic                      clk_sys,
    input  logic                      sys_rst,
    input  clk_rst_pkg::status_word_t status,
    input  logic                      osd_button,
    input  logic                      pll_locked,
    output logic                      game_rst
);
    import clk_rst_pkg::*;

    rst_sync_t rel_q;
    logic      sync_req;

    // Clocked request sources; the game also waits for a locked PLL
    assign sync_req = status[`CORE_STATUS_RST_BIT] | osd_button | ~pll_locked;

    ////////////////////////////////////////////////////////////////////////////
    // Release chain

    always_ff @(posedge clk_sys or posedge sys_rst) begin
        if (sys_rst) begin
            rel_q <= '1;
        end else if (sync_req) begin
            rel_q <= '1;
        end else begin
            // Zeros walk in from the bottom, one stage per cycle
            rel_q <= rel_q << 1;
        end
    end

    assign game_rst = rel_q[`CORE_RST_SYNC_STAGES-1];

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // Release only after the request was low on the first and last stage edge
    a_no_early_release : assert property (
        @(posedge clk_sys) disable iff (sys_rst)
        $fell(game_rst) |->
            !$past(sync_req) && !$past(sync_req, `CORE_RST_SYNC_STAGES)
    ) else $error("game_rst released while a reset request was active");

    // A sampled request must show up as game reset one cycle later
    a_req_asserts : assert property (
        @(posedge clk_sys) disable iff (sys_rst)
        sync_req |=> game_rst
    ) else $error("reset request did not assert game_rst");

endmodule

// ==== hdl/pll_lock_monitor.sv ====
////////////////////////////////////////////////////////////////////////////
// Watches the PLL lock and pulses the PLL reset after a lock loss
// pll_rst stays high for CORE_PLL_RST_CYCLES cycles from the detecting edge
// A further lock loss during the hold starts the count again
// pll_locked is assumed already synchronous to clk_sys
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_defs.svh"

module pll_lock_monitor (
    input  logic clk_sys,
    input  logic sys_rst,
    input  logic pll_locked,
    output logic pll_rst
);
    import clk_rst_pkg::*;

    localparam rst_count_t HOLD_LOAD = rst_count_t'(`CORE_PLL_RST_CYCLES - 1);

    pll_state_t state;
    rst_count_t hold_cnt;
    logic       locked_q;
    logic       lock_lost;

    // Falling edge of lock against the previous sample
    assign lock_lost = locked_q & ~pll_locked;

    ////////////////////////////////////////////////////////////////////////////
    // Supervisor FSM

    always_ff @(posedge clk_sys or posedge sys_rst) begin
        if (sys_rst) begin
            // Starts unlocked so a PLL still settling is not seen as a loss
            locked_q <= 1'b0;
            state    <= PLL_RUN;
            hold_cnt <= '0;
            pll_rst  <= 1'b0;
        end else begin
            locked_q <= pll_locked;
            case (state)
                PLL_RUN: begin
                    if (lock_lost) begin
                        state    <= PLL_HOLD;
                        hold_cnt <= HOLD_LOAD;
                        pll_rst  <= 1'b1;
                    end
                end
                PLL_HOLD: begin
                    if (lock_lost) begin
                        // Restart the full hold
                        hold_cnt <= HOLD_LOAD;
                    end else if (hold_cnt != '0) begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end else begin
                        state   <= PLL_RUN;
                        pll_rst <= 1'b0;
                    end
                end
                default: begin
                    state   <= PLL_RUN;
                    pll_rst <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    // A hold never ends before CORE_PLL_RST_CYCLES cycles of PLL reset
    a_hold_length : assert property (
        @(posedge clk_sys) disable iff (sys_rst)
        $fell(pll_rst) |-> $past(pll_rst, `CORE_PLL_RST_CYCLES)
    ) else $error("PLL reset hold ended early");

    // A detected loss always leaves the PLL in reset on the next cycle
    a_loss_holds : assert property (
        @(posedge clk_sys) disable iff (sys_rst)
        lock_lost |=> pll_rst && hold_cnt == HOLD_LOAD
    ) else $error("lock loss did not start a full PLL reset hold");

endmodule

// ==== list.f ====
+incdir+hdl
hdl/clk_rst_pkg.sv
hdl/av_pkg.sv
hdl/pll_lock_monitor.sv
hdl/game_reset_ctrl.sv
hdl/av_strobe_align.sv
hdl/core_glue_top.sv
tb/core_glue_checker.sv
tb/tb_core_glue.sv

// ==== tb/core_glue_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Reference model and scoreboard for the board glue top
// Expected outputs come from the DUT inputs only, updated on clk_sys
// Outputs are compared on the falling edge, where they are stable
// test_name and test_end come from the stimulus loop to mark each test
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_defs.svh"

module core_glue_checker (
    input  logic                      clk_sys,
    input  logic                      sys_rst,
    input  logic                      pll_locked,
    input  clk_rst_pkg::status_word_t status,
    input  logic                      osd_button,
    input  logic                      pxl2_cen,
    input  logic                      pxl_cen,
    input  av_pkg::snd_sample_t       snd_left,
    input  av_pkg::snd_sample_t       snd_right,
    input  logic                      snd_sample,
    input  logic                      pll_rst,
    input  logic                      game_rst,
    input  logic                      pxl1_cen,
    input  av_pkg::snd_sample_t       audio_l,
    input  av_pkg::snd_sample_t       audio_r,
    input  logic [8*12-1:0]           test_name,
    input  logic                      test_end,
    output int                        tests_passed,
    output int                        tests_failed,
    output int                        error_count
);
    import av_pkg::*;

    // Model state
    logic        locked_q;
    logic        loss_seen;
    int          cyc;
    int          loss_cyc;
    int          low_edges;
    logic        exp_pll;
    logic        exp_game;
    logic        exp_pxl1;
    snd_sample_t exp_l;
    snd_sample_t exp_r;

    int n_pass    = 0;
    int n_fail    = 0;
    int n_err     = 0;
    int test_errs = 0;

    assign tests_passed = n_pass;
    assign tests_failed = n_fail;
    assign error_count  = n_err;

    task automatic compare_output(input string what, input logic [31:0] got,
                                  input logic [31:0] exp);
        if (got != exp) begin
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            n_err     = n_err + 1;
            test_errs = test_errs + 1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Expected values

    always @(posedge clk_sys or posedge sys_rst) begin
        if (sys_rst) begin
            locked_q  = 1'b0;
            loss_seen = 1'b0;
            cyc       = 0;
            loss_cyc  = 0;
            low_edges = 0;
            exp_pll   = 1'b0;
            exp_game  = 1'b1;
            exp_pxl1  = 1'b0;
            exp_l     = '0;
            exp_r     = '0;
        end else begin
            cyc = cyc + 1;
            // Lock loss edge restarts the hold window
            if (locked_q && !pll_locked) begin
                loss_seen = 1'b1;
                loss_cyc  = cyc;
            end
            locked_q = pll_locked;
            exp_pll  = loss_seen && (cyc - loss_cyc < `CORE_PLL_RST_CYCLES);

            // Count edges with every request low
            if (status[`CORE_STATUS_RST_BIT] || osd_button || !pll_locked) begin
                low_edges = 0;
            end else if (low_edges < `CORE_RST_SYNC_STAGES) begin
                low_edges = low_edges + 1;
            end
            exp_game = low_edges < `CORE_RST_SYNC_STAGES;

            exp_pxl1 = pxl2_cen && !pxl_cen;
            if (snd_sample) begin
                exp_l = snd_left;
                exp_r = snd_right;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare and per-test report

    always @(negedge clk_sys) begin
        compare_output("pll_rst", 32'(pll_rst), 32'(exp_pll));
        compare_output("game_rst", 32'(game_rst), 32'(exp_game));
        compare_output("pxl1_cen", 32'(pxl1_cen), 32'(exp_pxl1));
        compare_output("audio_l", 32'(audio_l), 32'(exp_l));
        compare_output("audio_r", 32'(audio_r), 32'(exp_r));
        if (test_end) begin
            if (test_errs == 0) begin
                $display("%s: passed", test_name);
                n_pass = n_pass + 1;
            end else begin
                $display("%s: failed with %0d errors", test_name, test_errs);
                n_fail = n_fail + 1;
            end
            test_errs = 0;
        end
    end

endmodule

// ==== tb/tb_core_glue.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the board glue top
// Tests run from a table, one entry per test, in order
// Random pixel enables and audio samples come from a 32-bit Fibonacci LFSR
// Inputs change on the rising edge, the checker compares on the falling one
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "core_defs.svh"

module tb_core_glue;

    localparam int N_TESTS    = 7;
    localparam int CLK_PERIOD = 40;
    localparam int DROP_LEN   = 4;

    logic                      clk_sys;
    logic                      sys_rst;
    logic                      pll_locked;
    clk_rst_pkg::status_word_t status;
    logic                      osd_button;
    logic                      pxl2_cen;
    logic                      pxl_cen;
    av_pkg::snd_sample_t       snd_left;
    av_pkg::snd_sample_t       snd_right;
    logic                      snd_sample;
    logic                      pll_rst;
    logic                      game_rst;
    logic                      pxl1_cen;
    av_pkg::snd_sample_t       audio_l;
    av_pkg::snd_sample_t       audio_r;

    logic [8*12-1:0] test_name;
    logic            test_end;
    int              tests_passed;
    int              tests_failed;
    int              error_count;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table, -1 marks an event that a test does not use

    logic [8*12-1:0] t_name  [N_TESTS];
    int              t_len   [N_TESTS];
    int              t_drop1 [N_TESTS];
    int              t_drop2 [N_TESTS];
    int              t_stat  [N_TESTS];
    int              t_btn   [N_TESTS];
    logic            t_pix   [N_TESTS];
    logic            t_snd   [N_TESTS];

    logic [31:0] lfsr_state  = 32'hd51e6e62;
    logic        table_ready = 1'b0;

    core_glue_top dut (
        .clk_sys    ( clk_sys    ),
        .sys_rst    ( sys_rst    ),
        .pll_locked ( pll_locked ),
        .status     ( status     ),
        .osd_button ( osd_button ),
        .pxl2_cen   ( pxl2_cen   ),
        .pxl_cen    ( pxl_cen    ),
        .snd_left   ( snd_left   ),
        .snd_right  ( snd_right  ),
        .snd_sample ( snd_sample ),
        .pll_rst    ( pll_rst    ),
        .game_rst   ( game_rst   ),
        .pxl1_cen   ( pxl1_cen   ),
        .audio_l    ( audio_l    ),
        .audio_r    ( audio_r    )
    );

    core_glue_checker u_checker (
        .clk_sys      ( clk_sys      ),
        .sys_rst      ( sys_rst      ),
        .pll_locked   ( pll_locked   ),
        .status       ( status       ),
        .osd_button   ( osd_button   ),
        .pxl2_cen     ( pxl2_cen     ),
        .pxl_cen      ( pxl_cen      ),
        .snd_left     ( snd_left     ),
        .snd_right    ( snd_right    ),
        .snd_sample   ( snd_sample   ),
        .pll_rst      ( pll_rst      ),
        .game_rst     ( game_rst     ),
        .pxl1_cen     ( pxl1_cen     ),
        .audio_l      ( audio_l      ),
        .audio_r      ( audio_r      ),
        .test_name    ( test_name    ),
        .test_end     ( test_end     ),
        .tests_passed ( tests_passed ),
        .tests_failed ( tests_failed ),
        .error_count  ( error_count  )
    );

    // Taps 32, 22, 2, 1; one step per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic av_pkg::snd_sample_t random_sample();
        av_pkg::snd_sample_t s;
        s = '0;
        for (int b = 0; b < `CORE_SND_W; b++) begin
            s = {s[`CORE_SND_W-2:0], next_bit()};
        end
        return s;
    endfunction

    function automatic logic within_pulse(input int c, input int start, input int len);
        return start >= 0 && c >= start && c < start + len;
    endfunction

    task automatic add_test(input int idx, input logic [8*12-1:0] name, input int len,
                            input int drop1, input int drop2, input int stat,
                            input int btn, input logic pix, input logic snd);
        t_name[idx]  = name;
        t_len[idx]   = len;
        t_drop1[idx] = drop1;
        t_drop2[idx] = drop2;
        t_stat[idx]  = stat;
        t_btn[idx]   = btn;
        t_pix[idx]   = pix;
        t_snd[idx]   = snd;
    endtask

    task automatic load_table();
        add_test(0, "reset       ",  20, -1,  -1, -1, -1, 1'b0, 1'b0);
        add_test(1, "lock_drop   ", 300,  5,  -1, -1, -1, 1'b0, 1'b0);
        // Second drop lands inside the first hold
        add_test(2, "lock_redrop ", 420,  5, 105, -1, -1, 1'b0, 1'b0);
        add_test(3, "status_rst  ",  20, -1,  -1,  5, -1, 1'b0, 1'b0);
        add_test(4, "osd_button  ",  20, -1,  -1, -1,  5, 1'b0, 1'b0);
        add_test(5, "pixel_cen   ", 200, -1,  -1, -1, -1, 1'b1, 1'b0);
        add_test(6, "audio       ", 200, -1,  -1, -1, -1, 1'b0, 1'b1);
    endtask

    // Drives one cycle of test i at cycle c
    task automatic apply_cycle(input int i, input int c);
        logic drop;
        drop = within_pulse(c, t_drop1[i], DROP_LEN) || within_pulse(c, t_drop2[i], DROP_LEN);
        pll_locked <= !drop;
        status     <= '0;
        status[`CORE_STATUS_RST_BIT] <= within_pulse(c, t_stat[i], 1);
        osd_button <= within_pulse(c, t_btn[i], 1);
        if (t_pix[i]) begin
            pxl2_cen <= next_bit();
            pxl_cen  <= next_bit();
        end else begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end
        if (t_snd[i]) begin
            snd_left   <= random_sample();
            snd_right  <= random_sample();
            // Strobe on about one cycle in four
            snd_sample <= next_bit() & next_bit();
        end else begin
            snd_sample <= 1'b0;
        end
        test_name <= t_name[i];
        test_end  <= (c == t_len[i] - 1);
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        sys_rst    = 1'b1;
        pll_locked = 1'b1;
        status     = '0;
        osd_button = 1'b0;
        pxl2_cen   = 1'b0;
        pxl_cen    = 1'b0;
        snd_left   = '0;
        snd_right  = '0;
        snd_sample = 1'b0;
        test_name  = '0;
        test_end   = 1'b0;
        load_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk_sys);
        sys_rst <= 1'b0;

        for (int i = 0; i < N_TESTS; i++) begin
            for (int c = 0; c < t_len[i]; c++) begin
                @(posedge clk_sys);
                apply_cycle(i, c);
            end
        end

        // Quiet inputs and let the last results settle
        @(posedge clk_sys);
        pll_locked <= 1'b1;
        status     <= '0;
        osd_button <= 1'b0;
        pxl2_cen   <= 1'b0;
        pxl_cen    <= 1'b0;
        snd_sample <= 1'b0;
        test_end   <= 1'b0;
        repeat (4) @(posedge clk_sys);

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0 && tests_passed == N_TESTS) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int total;
        wait (table_ready);
        total = 0;
        for (int i = 0; i < N_TESTS; i++) begin
            total = total + t_len[i];
        end
        #((total + 100) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", total + 100);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
